/* Makefile */
TOP = tb_umi_endpoint

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f list.f

run: compile
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf obj_dir

/* list.f */
+incdir+.
umi_pkg.sv
umi_decode.sv
umi_rx.sv
umi_mem_exec.sv
umi_tx.sv
umi_endpoint.sv
umi_checker.sv
tb_clkgen.sv
tb_umi_endpoint.sv

/* tb_clkgen.sv */
`timescale 1ns/100ps

module tb_clkgen (
   output logic clk,
   output logic rst_n
);

   initial clk = 1'b0;
   always #50 clk = ~clk; // 100 ns period

   initial begin
      rst_n = 1'b0;
      repeat (8) @(posedge clk);
      rst_n <= 1'b1; // released just after an edge
   end

endmodule

/* tb_umi_endpoint.sv */
`timescale 1ns/100ps
`include "umi_defines.svh"

module tb_umi_endpoint import umi_pkg::*; ;

   localparam int rst_cycles = 8;
   localparam int n_directed = 100; // directed requests plus idle gaps, rounded up
   localparam int n_random   = 400;
   localparam int margin     = 50;
   localparam int run_cycles = rst_cycles + n_directed + n_random + margin;

   typedef struct packed {
      int       tag; // negedge count right after issue
      umi_pkt_t pkt;
   } exp_t;

   logic        clk;
   logic        rst_n;
   logic        req_valid;
   umi_pkt_t    req;
   logic        resp_valid;
   umi_pkt_t    resp;
   logic [15:0] drop_count;

   logic [31:0] rng_state = 32'd76;
   logic [31:0] ref_mem [`UMI_MEM_DEPTH]; // reference memory
   exp_t        exp_q [$];
   exp_t        head;
   int          cyc = 0;
   int          model_drops = 0;
   int          drop_seen_exp = 0; // what drop_count must show at this negedge
   bit          checking = 1'b0;
   string       cur_test = "reset";

   tb_clkgen u_clkgen (.clk(clk), .rst_n(rst_n));

   umi_endpoint u_dut (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .resp_valid (resp_valid),
      .resp       (resp),
      .drop_count (drop_count)
   );

   always @(posedge clk) cyc <= cyc + 1;

   function automatic logic [31:0] next_rand();
      rng_state = rng_state * 32'd1103515245 + 32'd12345; // lcg step
      return rng_state;
   endfunction

   // word index in addr[5:2], the other address bits are random
   function automatic umi_pkt_t mk_pkt(input logic [7:0] c, input logic [3:0] w,
                                       input logic [31:0] d);
      logic [31:0] r;
      r = next_rand();
      return '{cmd: c, addr: {r[31:6], w, r[1:0]}, data: d};
   endfunction

   function automatic logic [31:0] atomic_result(input logic [3:0] sub,
                                                 input logic [31:0] o, input logic [31:0] d);
      logic [31:0] so;
      logic [31:0] sd;
      so = o ^ 32'h8000_0000; // offset binary, signed order as unsigned
      sd = d ^ 32'h8000_0000;
      case (sub)
         4'd0: return o + d;
         4'd1: return o & d;
         4'd2: return o | d;
         4'd3: return o ^ d;
         4'd4: return (sd > so) ? d : o; // signed max
         4'd5: return (sd < so) ? d : o; // signed min
         4'd6: return (d > o) ? d : o;
         4'd7: return (d < o) ? d : o;
         default: return d;              // swap
      endcase
   endfunction

   // applies one request to the model, returns the expected response
   task automatic model_apply(input umi_pkt_t p, output bit has_resp,
                             output umi_pkt_t e, output bit dropped);
      logic [3:0]  w;
      logic [31:0] old;
      w        = p.addr[5:2];
      old      = ref_mem[w];
      has_resp = 1'b0;
      dropped  = 1'b0;
      e        = '{cmd: UMI_RESP_READ, addr: p.addr, data: old};
      if (p.cmd[0]) begin
         dropped = 1'b1; // any response code
      end else begin
         case (p.cmd[3:0])
            4'h2: has_resp = 1'b1;
            4'h4: ref_mem[w] = p.data;
            4'h6: begin
               ref_mem[w] = p.data;
               has_resp   = 1'b1;
               e          = '{cmd: UMI_RESP_WRITE, addr: p.addr, data: 32'h0};
            end
            4'h8: begin
               if (p.cmd[7:4] > 4'd8) begin
                  dropped = 1'b1;
               end else begin
                  ref_mem[w] = atomic_result(p.cmd[7:4], old, p.data);
                  has_resp   = 1'b1;
               end
            end
            default: dropped = 1'b1; // invalid, stream, multicast, unknown
         endcase
      end
   endtask

   task automatic send(input umi_pkt_t p);
      bit       has_resp;
      bit       dropped;
      umi_pkt_t e;
      @(posedge clk);
      drop_seen_exp = model_drops;
      model_apply(p, has_resp, e, dropped);
      if (dropped) model_drops++;
      if (has_resp) exp_q.push_back('{tag: cyc + 1, pkt: e});
      req_valid <= 1'b1;
      req       <= p;
   endtask

   task automatic idle(input int n);
      repeat (n) begin
         @(posedge clk);
         drop_seen_exp = model_drops;
         req_valid <= 1'b0;
      end
   endtask

   function automatic umi_pkt_t rand_pkt();
      logic [31:0] r;
      logic [31:0] s;
      logic [7:0]  c;
      r = next_rand();
      s = next_rand();
      case (r[27:24])
         4'd0, 4'd1, 4'd2, 4'd3: c = UMI_REQ_READ;
         4'd4, 4'd5:             c = UMI_REQ_POSTED;
         4'd6, 4'd7:             c = UMI_REQ_WRITE;
         4'd13:                  c = UMI_INVALID;
         4'd14:                  c = {s[31:25], 1'b1};  // responses
         4'd15: begin
            case (s[29:28])
               2'd0:    c = {s[27:24], 4'hA};          // stream
               2'd1:    c = UMI_REQ_MULTICAST;
               2'd2:    c = 8'h0E;                     // no such opcode
               default: c = {2'b11, s[31:30], 4'h8};  // bad atomic sub-code
            endcase
         end
         default:                c = {s[31:28] % 4'd9, 4'h8};
      endcase
      return mk_pkt(c, {r[29:28], r[29:28]}, next_rand()); // 4 hot words
   endfunction

   task automatic check_eq(input string field, input logic [31:0] exp,
                           input logic [31:0] act);
      assert (exp === act) else begin
         $display("FAIL %s %s: expected %h actual %h", cur_test, field, exp, act);
         $display("TESTBENCH FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // outputs compared mid-cycle
   always @(negedge clk) begin
      if (checking) begin
         assert (u_dut.u_checker.fired !== 1'b1) else begin
            $display("%s: a bound assertion on the endpoint fired", cur_test);
            $display("TESTBENCH FAILED");
            $fatal(1, "checker assertion");
         end
         check_eq("drop_count", drop_seen_exp, {16'h0, drop_count});
         if (resp_valid) begin
            assert (exp_q.size() > 0) else begin
               $display("%s: response came out with no request outstanding", cur_test);
               $display("TESTBENCH FAILED");
               $fatal(1, "unexpected response");
            end
            head = exp_q.pop_front();
            check_eq("resp cycle", head.tag + 3, cyc);
            check_eq("resp cmd", {24'h0, head.pkt.cmd}, {24'h0, resp.cmd});
            check_eq("resp addr", head.pkt.addr, resp.addr);
            check_eq("resp data", head.pkt.data, resp.data);
         end else if (exp_q.size() > 0) begin
            assert (cyc < exp_q[0].tag + 3) else begin
               $display("%s: expected response did not arrive in time", cur_test);
               $display("TESTBENCH FAILED");
               $fatal(1, "missing response");
            end
         end
      end
   end

   initial begin
      #(run_cycles * 100);
      $display("TESTBENCH FAILED");
      $fatal(1, "watchdog: run went past %0d cycles", run_cycles);
   end

   initial begin
      logic [7:0] bad_cmds [8];
      bad_cmds  = '{8'h00, 8'h03, 8'h07, 8'h0A, 8'h0C, 8'h0E, 8'h98, 8'h01};
      req_valid = 1'b0;
      req       = '0;
      ref_mem   = '{default: '0};
      wait (rst_n === 1'b1);
      checking = 1'b1;

      cur_test = "read_cleared"; // memory is zero after reset
      for (int i = 0; i < 4; i++) send(mk_pkt(UMI_REQ_READ, i[3:0], next_rand()));
      idle(4);

      cur_test = "write_read";
      send(mk_pkt(UMI_REQ_WRITE, 4'd1, 32'hcafe_0001));
      send(mk_pkt(UMI_REQ_POSTED, 4'd2, 32'h1234_5678));
      send(mk_pkt(UMI_REQ_READ, 4'd1, 32'h0));
      send(mk_pkt(UMI_REQ_READ, 4'd2, 32'h0));
      idle(4);

      // negative base vs small operand splits signed from unsigned
      cur_test = "atomics";
      for (int s = 0; s < 9; s++) begin
         send(mk_pkt(UMI_REQ_POSTED, 4'd3, 32'hffff_fff0));
         send(mk_pkt({s[3:0], 4'h8}, 4'd3, 32'h0000_0025));
         send(mk_pkt(UMI_REQ_READ, 4'd3, 32'h0));
      end
      idle(4);

      cur_test = "drops";
      foreach (bad_cmds[k]) send(mk_pkt(bad_cmds[k], 4'd2, next_rand()));
      send(mk_pkt(UMI_REQ_READ, 4'd2, 32'h0)); // pipe still alive
      idle(4);

      cur_test = "random_mix";
      repeat (n_random) send(rand_pkt());
      idle(6);

      assert (exp_q.size() == 0) else begin
         $display("%0d expected responses never came out", exp_q.size());
         $display("TESTBENCH FAILED");
         $fatal(1, "responses outstanding");
      end
      check_eq("drop total", model_drops, {16'h0, drop_count});
      $display("TESTBENCH PASSED");
      $finish;
   end

endmodule

/* umi_checker.sv */
`timescale 1ns/100ps

module umi_checker (
   input logic        clk,
   input logic        rst_n,
   input logic        req_valid,
   input logic        resp_valid,
   input logic [15:0] drop_count
);

   logic fired = 1'b0; // sticky, seen by the testbench

   a_resp_known: assert property (@(posedge clk) disable iff (!rst_n)
      !$isunknown(resp_valid))
      else begin
         fired = 1'b1;
         $error("resp_valid is unknown after reset");
      end

   // counter only ever goes up or holds
   a_drop_mono: assert property (@(posedge clk) disable iff (!rst_n)
      drop_count >= $past(drop_count))
      else begin
         fired = 1'b1;
         $error("drop_count went down");
      end

   a_resp_lat: assert property (@(posedge clk) disable iff (!rst_n)
      resp_valid |-> $past(req_valid, 3)) // fixed 3 cycle pipe
      else begin
         fired = 1'b1;
         $error("resp_valid without a request three cycles before");
      end

endmodule

bind umi_endpoint umi_checker u_checker (
   .clk        (clk),
   .rst_n      (rst_n),
   .req_valid  (req_valid),
   .resp_valid (resp_valid),
   .drop_count (drop_count)
);

/* umi_decode.sv */
`timescale 1ns/100ps

module umi_decode import umi_pkg::*; (
   input  logic [7:0] command, // packet command byte
   output umi_dec_t   dec      // decoded flags
);

   // invalid is the all-zero byte only
   assign dec.invalid  = (command == UMI_INVALID);

   // request/response split on bit 0
   assign dec.request  = ~command[0];
   assign dec.response =  command[0];

   // reads
   assign dec.read     = (command[3:0] == UMI_REQ_READ[3:0]);

   // writes
   assign dec.write           = ~dec.read;
   assign dec.write_posted    = (command[3:0] == UMI_REQ_POSTED[3:0]);
   assign dec.write_ack       = (command[3:0] == UMI_REQ_WRITE[3:0]); // acked request
   assign dec.write_response  = (command[3:0] == UMI_RESP_WRITE[3:0]);
   assign dec.write_stream    = (command[3:0] == UMI_REQ_STREAM[3:0]);
   assign dec.write_multicast = (command[3:0] == UMI_REQ_MULTICAST[3:0]);
   assign dec.write_signal    = 1'b0; // no eot support

   // read-modify-write, opcode on low nibble
   assign dec.atomic      = (command[3:0] == UMI_REQ_ATOMIC[3:0]);

   // sub-codes need the whole byte
   assign dec.atomic_add  = (command == UMI_REQ_ATOMICADD);
   assign dec.atomic_and  = (command == UMI_REQ_ATOMICAND);
   assign dec.atomic_or   = (command == UMI_REQ_ATOMICOR);
   assign dec.atomic_xor  = (command == UMI_REQ_ATOMICXOR);
   assign dec.atomic_max  = (command == UMI_REQ_ATOMICMAX);
   assign dec.atomic_min  = (command == UMI_REQ_ATOMICMIN);
   assign dec.atomic_maxu = (command == UMI_REQ_ATOMICMAXU);
   assign dec.atomic_minu = (command == UMI_REQ_ATOMICMINU);
   assign dec.atomic_swap = (command == UMI_REQ_ATOMICSWAP);

endmodule

/* umi_defines.svh */
`ifndef UMI_DEFINES_SVH
`define UMI_DEFINES_SVH

// packet field widths
`define UMI_AW 32 // address bits
`define UMI_DW 32 // data bits

// endpoint memory size in words
// word select is addr[5:2]
`define UMI_MEM_DEPTH 16

`endif

/* umi_endpoint.sv */
`timescale 1ns/100ps

module umi_endpoint import umi_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        req_valid,  // request strobe
   input  umi_pkt_t    req,
   output logic        resp_valid, // 3 cycles after req_valid
   output umi_pkt_t    resp,
   output logic [15:0] drop_count  // unserved commands
);

   logic        op_valid;
   umi_op_t     op;
   logic        res_valid;
   umi_result_t res;

   // capture, decode and filter
   umi_rx u_rx (
      .clk        (clk),
      .rst_n      (rst_n),
      .req_valid  (req_valid),
      .req        (req),
      .op_valid   (op_valid),
      .op         (op),
      .drop_count (drop_count)
   );

   // memory and rmw
   umi_mem_exec u_exec (
      .clk       (clk),
      .rst_n     (rst_n),
      .op_valid  (op_valid),
      .op        (op),
      .res_valid (res_valid),
      .res       (res)
   );

   // response builder
   umi_tx u_tx (
      .clk        (clk),
      .rst_n      (rst_n),
      .res_valid  (res_valid),
      .res        (res),
      .resp_valid (resp_valid),
      .resp       (resp)
   );

endmodule

/* umi_mem_exec.sv */
`timescale 1ns/100ps
`include "umi_defines.svh"

module umi_mem_exec import umi_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        op_valid,
   input  umi_op_t     op,
   output logic        res_valid, // one cycle after op_valid
   output umi_result_t res
);

   localparam int idx_w = $clog2(`UMI_MEM_DEPTH);

   logic [`UMI_DW-1:0] mem [`UMI_MEM_DEPTH];
   logic [idx_w-1:0]   idx;       // word select
   logic [`UMI_DW-1:0] old_word;  // current contents
   logic [`UMI_DW-1:0] wr_data;   // request operand
   logic [`UMI_DW-1:0] new_word;  // value written back
   logic               do_write;

   assign idx      = op.pkt.addr[idx_w+1:2]; // byte address to word
   assign old_word = mem[idx];
   assign wr_data  = op.pkt.data;
   assign do_write = op_valid & (op.kind != UMI_KIND_READ);

   // combine for atomics, plain data otherwise
   always_comb begin
      new_word = wr_data;
      if (op.kind == UMI_KIND_ATOMIC) begin
         case (1'b1)
            op.atop.add:    new_word = old_word + wr_data;
            op.atop.op_and: new_word = old_word & wr_data;
            op.atop.op_or:  new_word = old_word | wr_data;
            op.atop.op_xor: new_word = old_word ^ wr_data;
            op.atop.max:    new_word = ($signed(wr_data) > $signed(old_word)) ?
                                       wr_data : old_word;
            op.atop.min:    new_word = ($signed(wr_data) < $signed(old_word)) ?
                                       wr_data : old_word;
            op.atop.maxu:   new_word = (wr_data > old_word) ? wr_data : old_word;
            op.atop.minu:   new_word = (wr_data < old_word) ? wr_data : old_word;
            op.atop.swap:   new_word = wr_data;
            default:        new_word = wr_data;
         endcase
      end
   end

   // read and write back in one stage, so back-to-back ops see fresh data
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < `UMI_MEM_DEPTH; i++)
            mem[i] <= '0;
      end else if (do_write) begin
         mem[idx] <= new_word;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         res_valid <= 1'b0;
      else
         res_valid <= op_valid;
   end

   // result payload
   always_ff @(posedge clk) begin
      if (op_valid) begin
         res.kind <= op.kind;
         res.addr <= op.pkt.addr;
         res.data <= old_word; // old word for reads and atomics
      end
   end

endmodule

/* umi_pkg.sv */
`include "umi_defines.svh"

package umi_pkg;

   // low nibble is the opcode, bit 0 marks a response
   localparam logic [7:0] UMI_INVALID        = 8'h00;
   localparam logic [7:0] UMI_REQ_READ       = 8'h02;
   localparam logic [7:0] UMI_RESP_READ      = 8'h03;
   localparam logic [7:0] UMI_REQ_POSTED     = 8'h04;
   localparam logic [7:0] UMI_REQ_WRITE      = 8'h06; // write with ack
   localparam logic [7:0] UMI_RESP_WRITE     = 8'h07;
   localparam logic [7:0] UMI_REQ_ATOMIC     = 8'h08;
   localparam logic [7:0] UMI_REQ_STREAM     = 8'h0A; // not served
   localparam logic [7:0] UMI_REQ_MULTICAST  = 8'h0C; // not served

   // atomics, high nibble picks the operation
   localparam logic [7:0] UMI_REQ_ATOMICADD  = 8'h08;
   localparam logic [7:0] UMI_REQ_ATOMICAND  = 8'h18;
   localparam logic [7:0] UMI_REQ_ATOMICOR   = 8'h28;
   localparam logic [7:0] UMI_REQ_ATOMICXOR  = 8'h38;
   localparam logic [7:0] UMI_REQ_ATOMICMAX  = 8'h48;
   localparam logic [7:0] UMI_REQ_ATOMICMIN  = 8'h58;
   localparam logic [7:0] UMI_REQ_ATOMICMAXU = 8'h68;
   localparam logic [7:0] UMI_REQ_ATOMICMINU = 8'h78;
   localparam logic [7:0] UMI_REQ_ATOMICSWAP = 8'h88;

   // one packet, request or response
   typedef struct packed {
      logic [7:0]          cmd;
      logic [`UMI_AW-1:0]  addr;
      logic [`UMI_DW-1:0]  data;
   } umi_pkt_t;

   // decoder flags
   typedef struct packed {
      logic invalid;
      logic request;
      logic response;
      logic read;
      logic write;           // anything that is not a read
      logic write_posted;
      logic write_signal;    // eot write, always low
      logic write_ack;
      logic write_stream;
      logic write_response;
      logic write_multicast;
      logic atomic;          // any rmw opcode
      logic atomic_swap;
      logic atomic_add;
      logic atomic_and;
      logic atomic_or;
      logic atomic_xor;
      logic atomic_min;
      logic atomic_max;
      logic atomic_minu;
      logic atomic_maxu;
   } umi_dec_t;

   typedef enum logic [1:0] {
      UMI_KIND_READ,
      UMI_KIND_POSTED,
      UMI_KIND_ACK_WRITE,
      UMI_KIND_ATOMIC
   } umi_kind_e;

   // one-hot atomic operation
   typedef struct packed {
      logic swap;
      logic add;
      logic op_and;
      logic op_or;
      logic op_xor;
      logic min;
      logic max;
      logic minu;
      logic maxu;
   } umi_atop_t;

   // registered request into the exec stage
   typedef struct packed {
      umi_pkt_t   pkt;
      umi_atop_t  atop;
      umi_kind_e  kind;
   } umi_op_t;

   // exec result toward the response stage
   typedef struct packed {
      umi_kind_e           kind;
      logic [`UMI_AW-1:0]  addr;
      logic [`UMI_DW-1:0]  data; // old word
   } umi_result_t;

endpackage

/* umi_rx.sv */
`timescale 1ns/100ps

module umi_rx import umi_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        req_valid,  // one request per strobe
   input  umi_pkt_t    req,
   output logic        op_valid,   // to exec stage
   output umi_op_t     op,
   output logic [15:0] drop_count  // saturating
);

   umi_dec_t  dec;
   umi_atop_t atop;
   umi_kind_e kind;
   logic      atop_known;  // atomic with a legal sub-code
   logic      serve;       // request this endpoint handles

   umi_decode u_decode (
      .command (req.cmd),
      .dec     (dec)
   );

   // gather sub-code flags into the one-hot field
   assign atop.swap   = dec.atomic_swap;
   assign atop.add    = dec.atomic_add;
   assign atop.op_and = dec.atomic_and;
   assign atop.op_or  = dec.atomic_or;
   assign atop.op_xor = dec.atomic_xor;
   assign atop.min    = dec.atomic_min;
   assign atop.max    = dec.atomic_max;
   assign atop.minu   = dec.atomic_minu;
   assign atop.maxu   = dec.atomic_maxu;

   assign atop_known = dec.atomic & (|atop);

   // stream, multicast, responses and odd opcodes all fall out here
   assign serve = ~dec.invalid & dec.request &
                  (dec.read | dec.write_posted | dec.write_ack | atop_known);

   always_comb begin
      if (dec.read)              kind = UMI_KIND_READ;
      else if (dec.write_posted) kind = UMI_KIND_POSTED;
      else if (dec.write_ack)    kind = UMI_KIND_ACK_WRITE;
      else                       kind = UMI_KIND_ATOMIC;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         op_valid   <= 1'b0;
         drop_count <= '0;
      end else begin
         op_valid <= req_valid & serve;
         if (req_valid && !serve && drop_count != '1)
            drop_count <= drop_count + 16'd1; // hold at max
      end
   end

   // payload, qualified by op_valid
   always_ff @(posedge clk) begin
      if (req_valid) begin
         op.pkt  <= req;
         op.atop <= atop;
         op.kind <= kind;
      end
   end

endmodule

/* umi_tx.sv */
`timescale 1ns/100ps

module umi_tx import umi_pkg::*; (
   input  logic        clk,
   input  logic        rst_n,
   input  logic        res_valid,
   input  umi_result_t res,
   output logic        resp_valid, // response strobe
   output umi_pkt_t    resp
);

   logic     need_resp; // posted writes stay silent
   umi_pkt_t resp_nxt;

   assign need_resp = res_valid & (res.kind != UMI_KIND_POSTED);

   always_comb begin
      resp_nxt.addr = res.addr; // echo request address
      if (res.kind == UMI_KIND_ACK_WRITE) begin
         resp_nxt.cmd  = UMI_RESP_WRITE;
         resp_nxt.data = '0;
      end else begin
         // reads and atomics
         resp_nxt.cmd  = UMI_RESP_READ;
         resp_nxt.data = res.data;
      end
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n)
         resp_valid <= 1'b0;
      else
         resp_valid <= need_resp;
   end

   always_ff @(posedge clk) begin
      if (need_resp)
         resp <= resp_nxt;
   end

endmodule
